// File: tests/cpu_cases.txt
# P <byte address> <program word>  preloads one instruction word, little-endian
# W <byte address> <byte>          one expected bus write, listed in bus order
# setup: x1 = -5, x2 = 3
P 00000000 ffb00093
P 00000004 00300113
# addi x4, x1, -7
P 00000008 ff908213
P 0000000c 40402023
W 00000400 f4
W 00000401 ff
W 00000402 ff
W 00000403 ff
# slti x4, x1, 1
P 00000010 0010a213
P 00000014 40402223
W 00000404 01
W 00000405 00
W 00000406 00
W 00000407 00
# sltiu x4, x1, 1
P 00000018 0010b213
P 0000001c 40402423
W 00000408 00
W 00000409 00
W 0000040a 00
W 0000040b 00
# xori x4, x1, 0x0f0
P 00000020 0f00c213
P 00000024 40402623
W 0000040c 0b
W 0000040d ff
W 0000040e ff
W 0000040f ff
# ori x4, x2, 0x550
P 00000028 55016213
P 0000002c 40402823
W 00000410 53
W 00000411 05
W 00000412 00
W 00000413 00
# andi x4, x1, 0x0ff
P 00000030 0ff0f213
P 00000034 40402a23
W 00000414 fb
W 00000415 00
W 00000416 00
W 00000417 00
# slli x4, x2, 30
P 00000038 01e11213
P 0000003c 40402c23
W 00000418 00
W 00000419 00
W 0000041a 00
W 0000041b c0
# srli x4, x1, 4
P 00000040 0040d213
P 00000044 40402e23
W 0000041c ff
W 0000041d ff
W 0000041e ff
W 0000041f 0f
# srai x4, x1, 1
P 00000048 4010d213
P 0000004c 42402023
W 00000420 fd
W 00000421 ff
W 00000422 ff
W 00000423 ff
# add x4, x1, x2
P 00000050 00208233
P 00000054 42402223
W 00000424 fe
W 00000425 ff
W 00000426 ff
W 00000427 ff
# sub x4, x1, x2
P 00000058 40208233
P 0000005c 42402423
W 00000428 f8
W 00000429 ff
W 0000042a ff
W 0000042b ff
# sll x4, x1, x2
P 00000060 00209233
P 00000064 42402623
W 0000042c d8
W 0000042d ff
W 0000042e ff
W 0000042f ff
# slt x4, x1, x2
P 00000068 0020a233
P 0000006c 42402823
W 00000430 01
W 00000431 00
W 00000432 00
W 00000433 00
# sltu x4, x1, x2
P 00000070 0020b233
P 00000074 42402a23
W 00000434 00
W 00000435 00
W 00000436 00
W 00000437 00
# xor x4, x1, x2
P 00000078 0020c233
P 0000007c 42402c23
W 00000438 f8
W 00000439 ff
W 0000043a ff
W 0000043b ff
# srl x4, x1, x2
P 00000080 0020d233
P 00000084 42402e23
W 0000043c ff
W 0000043d ff
W 0000043e ff
W 0000043f 1f
# sra x4, x1, x2
P 00000088 4020d233
P 0000008c 44402023
W 00000440 ff
W 00000441 ff
W 00000442 ff
W 00000443 ff
# or x4, x1, x2
P 00000090 0020e233
P 00000094 44402223
W 00000444 fb
W 00000445 ff
W 00000446 ff
W 00000447 ff
# and x4, x1, x2
P 00000098 0020f233
P 0000009c 44402423
W 00000448 03
W 00000449 00
W 0000044a 00
W 0000044b 00
# lui x4, 0xabcde
P 000000a0 abcde237
P 000000a4 44402623
W 0000044c 00
W 0000044d e0
W 0000044e cd
W 0000044f ab
# addi x0, x1, 0x123 then sw x0
P 000000a8 12308013
P 000000ac 44002823
W 00000450 00
W 00000451 00
W 00000452 00
W 00000453 00
# lui x5, 0x30 then sw x2, 4(x5) halts the core
P 000000b0 000302b7
P 000000b4 0022a223
W 00030004 03
W 00030005 00
W 00030006 00
W 00030007 00
# never executed
P 000000b8 46202023
P 000000bc 46202223

// File: sim.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/memory_controller.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/execute_unit.sv
hdl/cpu.sv
tests/cpu_tb.sv

// File: Makefile
# Verilator build and run of the RV32I core testbench.
# Run from the project root, the testbench opens its cases file by relative path.

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/cpu_tb.sv
/* Testbench for the RV32I core. Preloads the program and the expected bus
   writes from the cases file, stalls rdy_in at random and checks every write. */
`timescale 1ns/1ps

module cpu_tb;

    localparam CASES_FILE      = "tests/cpu_cases.txt";
    localparam int MEM_BYTES       = 128 * 1024;
    localparam int DRAIN_CYCLES    = 50;
    localparam int CYCLES_PER_WORD = 40;
    localparam int CYCLE_MARGIN    = 200;

    logic           clk_in  = 1'b0;
    logic           rst_in  = 1'b1;
    logic           rdy_in  = 1'b1;
    isa_pkg::byte_t mem_din = '0;
    isa_pkg::byte_t mem_dout;
    isa_pkg::word_t mem_a;
    logic           mem_wr;

    isa_pkg::byte_t mem [MEM_BYTES];
    isa_pkg::word_t exp_addr [$];  // expected writes in bus order
    isa_pkg::byte_t exp_data [$];
    int             prog_words  = 0;
    int             cycle_limit = 0;
    int             cycles      = 0;
    logic [31:0]    lfsr        = 32'h9b4d5247;

    cpu #(.MEM_ADDR_WIDTH(18)) cpu_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
    );

    // fibonacci form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_bit(output logic b);
        b    = lfsr[31];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_write_addr(input isa_pkg::word_t got, input isa_pkg::word_t want);
        if (got !== want)
        begin
            $display("** Error at %0d ns: bus write to 0x%08h, expected address 0x%08h",
                     $time, got, want);
            abort_run();
        end
    endtask

    task automatic check_write_data(input isa_pkg::byte_t got, input isa_pkg::byte_t want);
        if (got !== want)
        begin
            $display("** Error at %0d ns: bus write data 0x%02h, expected 0x%02h",
                     $time, got, want);
            abort_run();
        end
    endtask

    task automatic check_bus_write(input isa_pkg::word_t addr, input isa_pkg::byte_t data);
        if (exp_addr.size() == 0)
        begin
            $display("bus write of 0x%02h to 0x%08h at %0d ns after the last expected write",
                     data, addr, $time);
            abort_run();
        end
        else
        begin
            check_write_addr(addr, exp_addr.pop_front());
            check_write_data(data, exp_data.pop_front());
            if (addr < isa_pkg::word_t'(MEM_BYTES))
                mem[addr[16:0]] = data;  // the stop address lies outside the model
        end
    endtask

    task automatic load_cases();
        int             fd;
        int             n;
        string          line;
        logic [7:0]     kind;
        isa_pkg::word_t addr;
        isa_pkg::word_t val;
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = isa_pkg::byte_t'(i ^ (i >> 8) ^ (i >> 16));
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open %s", CASES_FILE);
            abort_run();
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                kind = line.getc(0);
                n    = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, val);
                if (kind == "P" && n == 2)
                begin
                    for (int i = 0; i < core_pkg::BYTES_PER_WORD; i++)
                        mem[addr[16:0] + 17'(i)] = val[8*i +: 8];  // little-endian
                    prog_words++;
                end
                else if (kind == "W" && n == 2)
                begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(isa_pkg::byte_t'(val));
                end
                else if (kind != "#" && line.len() > 1)
                begin
                    $display("malformed line in %s: %s", CASES_FILE, line);
                    abort_run();
                end
            end
            $fclose(fd);
            if (exp_addr.size() == 0)
            begin
                $display("no expected bus writes found in %s", CASES_FILE);
                abort_run();
            end
        end
    endtask

    initial
    begin
        forever #5 clk_in = ~clk_in;
    end

    // memory model, random stall and write monitor
    always @(posedge clk_in)
    begin
        logic b0;
        logic b1;
        mem_din <= mem[mem_a[16:0]];  // data follows one cycle after the address
        if (!rst_in)
        begin
            cycles = cycles + 1;
            take_random_bit(b0);
            take_random_bit(b1);
            rdy_in <= b0 | b1;
            if (mem_wr)
                check_bus_write(mem_a, mem_dout);
        end
    end

    initial
    begin
        load_cases();
        cycle_limit = prog_words * CYCLES_PER_WORD + CYCLE_MARGIN;
        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;
        while (exp_addr.size() != 0 && cycles < cycle_limit)
            @(negedge clk_in);
        if (exp_addr.size() != 0)
        begin
            $display("timeout: halt store never seen");
            abort_run();
        end
        else
        begin
            // the words after the stop store must stay off the bus
            repeat (DRAIN_CYCLES) @(negedge clk_in);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: hdl/cpu.sv
/* Top level of the in-order RV32I core. Connects fetch, decode, execute,
   the register file and the byte-wide memory controller. */
`timescale 1ns/1ps

module cpu #(
    parameter int MEM_ADDR_WIDTH = 18
) (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           rdy_in,   // pauses the core when low
    input  isa_pkg::byte_t mem_din,
    output isa_pkg::byte_t mem_dout,
    output isa_pkg::word_t mem_a,
    output logic           mem_wr    // 1 for write
);

    logic                fetch_req;
    logic                fetch_done;
    isa_pkg::word_t      fetch_addr;
    isa_pkg::word_t      fetch_word;
    logic                store_req;
    logic                store_done;
    isa_pkg::word_t      store_addr;
    isa_pkg::word_t      exe_store_data;
    logic                retire;
    logic                halt;
    core_pkg::reg_idx_t  rs1_idx;
    core_pkg::reg_idx_t  rs2_idx;
    isa_pkg::word_t      rs1_val;
    isa_pkg::word_t      rs2_val;
    logic                uop_valid;
    logic                is_store;
    logic                writes_rd;
    core_pkg::reg_idx_t  rd_idx;
    isa_pkg::word_t      operand_a;
    isa_pkg::word_t      operand_b;
    isa_pkg::word_t      uop_store_data;
    core_pkg::alu_op_t   alu_op;
    logic                wr_en;
    core_pkg::reg_idx_t  wr_idx;
    isa_pkg::word_t      wr_val;

    memory_controller #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) memory_controller_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_done(fetch_done), .fetch_word(fetch_word),
        .store_req(store_req), .store_addr(store_addr),
        .store_data(exe_store_data), .store_done(store_done),
        .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr)
    );

    fetch_unit #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) fetch_unit_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .retire(retire), .store_done(store_done), .halt(halt),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr)
    );

    decoder decoder_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .fetch_done(fetch_done), .fetch_word(fetch_word),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .uop_valid(uop_valid), .is_store(is_store), .writes_rd(writes_rd),
        .rd_idx(rd_idx), .operand_a(operand_a), .operand_b(operand_b),
        .store_data(uop_store_data), .alu_op(alu_op)
    );

    regfile regfile_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_val(wr_val)
    );

    execute_unit execute_unit_i (
        .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
        .uop_valid(uop_valid), .is_store(is_store), .writes_rd(writes_rd),
        .rd_idx(rd_idx), .operand_a(operand_a), .operand_b(operand_b),
        .store_data(uop_store_data), .alu_op(alu_op), .store_done(store_done),
        .retire(retire), .wr_en(wr_en), .wr_idx(wr_idx), .wr_val(wr_val),
        .store_req(store_req), .store_addr(store_addr),
        .store_data_out(exe_store_data), .halt(halt)
    );

endmodule

// File: hdl/execute_unit.sv
/* ALU and store address generation. Retires a register result one cycle
   after the uop, or holds a store request until the bus has written it. */
`timescale 1ns/1ps

module execute_unit (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  logic               uop_valid,
    input  logic               is_store,
    input  logic               writes_rd,
    input  core_pkg::reg_idx_t rd_idx,
    input  isa_pkg::word_t     operand_a,
    input  isa_pkg::word_t     operand_b,
    input  isa_pkg::word_t     store_data,
    input  core_pkg::alu_op_t  alu_op,
    input  logic               store_done,
    output logic               retire,
    output logic               wr_en,
    output core_pkg::reg_idx_t wr_idx,
    output isa_pkg::word_t     wr_val,
    output logic               store_req,
    output isa_pkg::word_t     store_addr,
    output isa_pkg::word_t     store_data_out,
    output logic               halt
);

    isa_pkg::word_t result;
    logic [4:0]     shamt;

    assign shamt = operand_b[4:0];

    always_comb
    begin
        result = '0;
        case (alu_op)
            core_pkg::ALU_ADD:    result = operand_a + operand_b;  // also store address
            core_pkg::ALU_SUB:    result = operand_a - operand_b;
            core_pkg::ALU_SLL:    result = operand_a << shamt;
            core_pkg::ALU_SLT:    result = isa_pkg::word_t'($signed(operand_a) < $signed(operand_b));
            core_pkg::ALU_SLTU:   result = isa_pkg::word_t'(operand_a < operand_b);
            core_pkg::ALU_XOR:    result = operand_a ^ operand_b;
            core_pkg::ALU_SRL:    result = operand_a >> shamt;
            core_pkg::ALU_SRA:    result = $signed(operand_a) >>> shamt;
            core_pkg::ALU_OR:     result = operand_a | operand_b;
            core_pkg::ALU_AND:    result = operand_a & operand_b;
            core_pkg::ALU_PASS_B: result = operand_b;
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            retire    <= 1'b0;
            wr_en     <= 1'b0;
            store_req <= 1'b0;
            halt      <= 1'b0;
        end
        else if (rdy_in)
        begin
            retire <= uop_valid && !is_store;
            wr_en  <= uop_valid && !is_store && writes_rd;
            if (uop_valid && is_store)
            begin
                store_req <= 1'b1;
                halt      <= result == isa_pkg::STOP_ADDR;
            end
            else if (store_done)
            begin
                store_req <= 1'b0;
                halt      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && uop_valid)
        begin
            wr_idx         <= rd_idx;
            wr_val         <= result;
            store_addr     <= result;
            store_data_out <= store_data;
        end
    end

endmodule

// File: hdl/regfile.sv
/* 32 x 32-bit integer register file. Two combinational reads, one
   synchronous write; x0 always reads zero. */
`timescale 1ns/1ps

module regfile (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output isa_pkg::word_t     rs1_val,
    output isa_pkg::word_t     rs2_val,
    input  logic               wr_en,
    input  core_pkg::reg_idx_t wr_idx,
    input  isa_pkg::word_t     wr_val
);

    isa_pkg::word_t regs_q [32];

    assign rs1_val = regs_q[rs1_idx];
    assign rs2_val = regs_q[rs2_idx];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int i = 0; i < 32; i++)
                regs_q[i] <= '0;
        end
        else if (rdy_in && wr_en && wr_idx != '0)  // x0 stays zero
            regs_q[wr_idx] <= wr_val;
    end

endmodule

// File: hdl/decoder.sv
/* Decodes a fetched word into ALU operands, destination and store data.
   The uop leaves one cycle after the fetch completes. */
`timescale 1ns/1ps

module decoder (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  logic               fetch_done,
    input  isa_pkg::word_t     fetch_word,
    output core_pkg::reg_idx_t rs1_idx,
    output core_pkg::reg_idx_t rs2_idx,
    input  isa_pkg::word_t     rs1_val,
    input  isa_pkg::word_t     rs2_val,
    output logic               uop_valid,
    output logic               is_store,
    output logic               writes_rd,
    output core_pkg::reg_idx_t rd_idx,
    output isa_pkg::word_t     operand_a,
    output isa_pkg::word_t     operand_b,
    output isa_pkg::word_t     store_data,
    output core_pkg::alu_op_t  alu_op
);

    isa_pkg::opcode_t  opcode;
    isa_pkg::funct3_t  funct3;
    logic              alt;
    isa_pkg::word_t    imm_i;
    isa_pkg::word_t    imm_s;
    isa_pkg::word_t    imm_u;
    isa_pkg::word_t    b_d;
    core_pkg::alu_op_t op_d;
    logic              store_d;
    logic              wr_d;

    function automatic core_pkg::alu_op_t alu_from_funct3(input isa_pkg::funct3_t f3,
                                                          input logic sub_sra);
        case (f3)
            isa_pkg::F3_ADD:  return sub_sra ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            isa_pkg::F3_SLL:  return core_pkg::ALU_SLL;
            isa_pkg::F3_SLT:  return core_pkg::ALU_SLT;
            isa_pkg::F3_SLTU: return core_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:  return core_pkg::ALU_XOR;
            isa_pkg::F3_SR:   return sub_sra ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            isa_pkg::F3_OR:   return core_pkg::ALU_OR;
            isa_pkg::F3_AND:  return core_pkg::ALU_AND;
            default:          return core_pkg::ALU_ADD;
        endcase
    endfunction

    assign opcode  = fetch_word[6:0];
    assign funct3  = fetch_word[14:12];
    assign alt     = fetch_word[isa_pkg::FUNCT7_ALT_BIT];
    assign rs1_idx = fetch_word[19:15];
    assign rs2_idx = fetch_word[24:20];
    assign imm_i   = {{20{fetch_word[31]}}, fetch_word[31:20]};
    assign imm_s   = {{20{fetch_word[31]}}, fetch_word[31:25], fetch_word[11:7]};
    assign imm_u   = {fetch_word[31:12], 12'b0};

    always_comb
    begin
        b_d     = imm_i;
        op_d    = core_pkg::ALU_ADD;
        store_d = 1'b0;
        wr_d    = 1'b0;
        case (opcode)
            isa_pkg::OPC_OP_IMM:
            begin
                // bit 30 is part of the immediate except for srai
                op_d = alu_from_funct3(funct3, alt && funct3 == isa_pkg::F3_SR);
                wr_d = 1'b1;
            end
            isa_pkg::OPC_OP:
            begin
                b_d  = rs2_val;
                op_d = alu_from_funct3(funct3, alt);
                wr_d = 1'b1;
            end
            isa_pkg::OPC_LUI:
            begin
                b_d  = imm_u;
                op_d = core_pkg::ALU_PASS_B;
                wr_d = 1'b1;
            end
            isa_pkg::OPC_STORE:
            begin
                b_d     = imm_s;
                store_d = funct3 == isa_pkg::F3_SW;  // narrower stores retire as no-ops
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
            uop_valid <= 1'b0;
        else if (rdy_in)
            uop_valid <= fetch_done;
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in && fetch_done)
        begin
            rd_idx     <= fetch_word[11:7];
            operand_a  <= rs1_val;
            operand_b  <= b_d;
            store_data <= rs2_val;
            alu_op     <= op_d;
            is_store   <= store_d;
            writes_rd  <= wr_d;
        end
    end

endmodule

// File: hdl/fetch_unit.sv
/* Program counter and fetch sequencing. One fetch is issued after reset
   and one after each retired instruction, until a stop store. */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int MEM_ADDR_WIDTH = 18
) (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           rdy_in,
    input  logic           retire,
    input  logic           store_done,
    input  logic           halt,
    output logic           fetch_req,
    output isa_pkg::word_t fetch_addr
);

    localparam isa_pkg::word_t PC_MASK = (isa_pkg::word_t'(1) << MEM_ADDR_WIDTH) - 1;

    isa_pkg::word_t pc_q;
    logic           halted_q;
    logic           req_q;

    assign fetch_req  = req_q;
    assign fetch_addr = pc_q;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            pc_q     <= '0;
            halted_q <= 1'b0;
            req_q    <= 1'b1;
        end
        else if (rdy_in)
        begin
            if (halt)
                halted_q <= 1'b1;
            if (retire || store_done)
            begin
                req_q <= 1'b0;  // one low cycle rearms the controller
                pc_q  <= (pc_q + isa_pkg::word_t'(core_pkg::BYTES_PER_WORD)) & PC_MASK;
            end
            else if (!halted_q && !halt)
                req_q <= 1'b1;
        end
    end

endmodule

// File: hdl/memory_controller.sv
/* Turns one word fetch or word store into four byte transfers on the
   memory bus, little-endian. Stores win over fetches. */
`timescale 1ns/1ps

module memory_controller #(
    parameter int MEM_ADDR_WIDTH = 18
) (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           rdy_in,
    input  logic           fetch_req,
    input  isa_pkg::word_t fetch_addr,
    output logic           fetch_done,
    output isa_pkg::word_t fetch_word,
    input  logic           store_req,
    input  isa_pkg::word_t store_addr,
    input  isa_pkg::word_t store_data,
    output logic           store_done,
    input  isa_pkg::byte_t mem_din,
    output isa_pkg::byte_t mem_dout,
    output isa_pkg::word_t mem_a,
    output logic           mem_wr
);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} state_t;

    localparam isa_pkg::word_t ADDR_MASK = (isa_pkg::word_t'(1) << MEM_ADDR_WIDTH) - 1;

    state_t              state_q;
    core_pkg::byte_cnt_t cnt_q;
    logic                pend_q;    // a read address is waiting for its data
    logic                served_q;  // current fetch already answered
    logic                fetch_done_q;
    logic                store_done_q;
    isa_pkg::word_t      base_q;
    isa_pkg::word_t      data_q;
    isa_pkg::word_t      byte_addr;
    logic                last_byte;
    logic                start_wr;
    logic                start_rd;

    assign last_byte = cnt_q == core_pkg::byte_cnt_t'(core_pkg::BYTES_PER_WORD - 1);
    assign start_wr  = (state_q == ST_IDLE) && store_req && !store_done_q;
    assign start_rd  = (state_q == ST_IDLE) && fetch_req && !served_q && !start_wr;

    // during a stall the pending byte is requested again, its data would be lost
    assign byte_addr = base_q + isa_pkg::word_t'(cnt_q) + isa_pkg::word_t'(rdy_in & pend_q);
    assign mem_a     = byte_addr & ADDR_MASK;
    assign mem_wr    = (state_q == ST_WRITE) && rdy_in;
    assign mem_dout  = isa_pkg::byte_t'(data_q >> {cnt_q, 3'b000});

    assign fetch_done = fetch_done_q;
    assign fetch_word = data_q;
    assign store_done = store_done_q;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state_q      <= ST_IDLE;
            cnt_q        <= '0;
            pend_q       <= 1'b0;
            served_q     <= 1'b0;
            fetch_done_q <= 1'b0;
            store_done_q <= 1'b0;
        end
        else if (rdy_in)
        begin
            fetch_done_q <= 1'b0;
            store_done_q <= 1'b0;
            if (!fetch_req)
                served_q <= 1'b0;
            case (state_q)
                ST_IDLE:
                begin
                    cnt_q <= '0;
                    if (start_wr)
                        state_q <= ST_WRITE;
                    else if (start_rd)
                        state_q <= ST_READ;
                end
                ST_READ:
                begin
                    pend_q <= 1'b1;
                    if (pend_q)
                    begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_byte)
                        begin
                            state_q      <= ST_IDLE;
                            pend_q       <= 1'b0;
                            served_q     <= 1'b1;
                            fetch_done_q <= 1'b1;
                        end
                    end
                end
                ST_WRITE:
                begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_byte)
                    begin
                        state_q      <= ST_IDLE;
                        store_done_q <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (start_wr)
            begin
                base_q <= store_addr;
                data_q <= store_data;
            end
            else if (start_rd)
                base_q <= fetch_addr;
            else if (state_q == ST_READ && pend_q)
                data_q[{cnt_q, 3'b000} +: 8] <= mem_din;  // little-endian assembly
        end
    end

endmodule

// File: hdl/core_pkg.sv
/* Types internal to the core: register index, ALU operations and the
   byte counter of the memory bus. */
package core_pkg;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_t;

    localparam int BYTES_PER_WORD = 4;

    // byte position inside a word on the 8-bit bus
    typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_cnt_t;

endpackage

// File: hdl/isa_pkg.sv
/* RV32I encoding constants shared by the decoder and the execute stage.
   Only the subset run by this core is listed. */
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // funct3 for OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl, sra and immediate forms
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 of a store
    localparam funct3_t F3_SW = 3'b010;

    // instruction bit that turns add into sub and srl into sra
    localparam int FUNCT7_ALT_BIT = 30;

    // a store here stops the core
    localparam word_t STOP_ADDR = 32'h0003_0004;

endpackage
